// File: source/ram_bank_pkg.sv
// Widths, vector types, optimization mode enum, latency constants and bus/bank structs
package ram_bank_pkg;

    // ------------------------------
    // Geometry
    // ------------------------------
    localparam int NUM_BANKS     = 4;
    localparam int BANK_SEL_WID  = 2;
    localparam int WORD_ADDR_WID = 8;
    localparam int BUS_ADDR_WID  = BANK_SEL_WID + WORD_ADDR_WID;
    localparam int DATA_WID      = 32;

    typedef logic [WORD_ADDR_WID-1:0] word_addr_t;
    typedef logic [BUS_ADDR_WID-1:0]  bus_addr_t;
    typedef logic [BANK_SEL_WID-1:0]  bank_sel_t;
    typedef logic [DATA_WID-1:0]      data_t;

    // ------------------------------
    // Optimization mode and latency
    // ------------------------------
    typedef enum logic {
        OPT_MODE_TIMING,
        OPT_MODE_LATENCY
    } opt_mode_t;

    localparam opt_mode_t OPT_MODE = OPT_MODE_TIMING;

    // Write ack is the same in both modes
    localparam int WR_LATENCY         = 1;
    localparam int RD_LATENCY_TIMING  = 2;
    localparam int RD_LATENCY_LATENCY = 1;

    // ------------------------------
    // Bus and bank structs
    // ------------------------------
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        bus_addr_t adr;
        data_t     dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic       en;
        logic       we;
        word_addr_t addr;
        data_t      data;
    } bank_req_t;

    typedef struct packed {
        logic  ack;
        data_t data;
    } bank_rsp_t;

endpackage : ram_bank_pkg

// File: source/ram_sdp_core.sv
// Behavioral simple dual-port storage array with optional second read register
`timescale 1ns/1ps

module ram_sdp_core #(
    parameter ram_bank_pkg::opt_mode_t opt_mode = ram_bank_pkg::OPT_MODE_TIMING
) (
    input  logic                     rd_clk,

    // Write port
    input  logic                     wr_en,
    input  ram_bank_pkg::word_addr_t wr_addr,
    input  ram_bank_pkg::data_t      wr_data,

    // Read port
    input  logic                     rd_en,
    input  ram_bank_pkg::word_addr_t rd_addr,
    output ram_bank_pkg::data_t      rd_data
);

    localparam int DEPTH = 2 ** ram_bank_pkg::WORD_ADDR_WID;

    ram_bank_pkg::data_t mem [DEPTH];
    ram_bank_pkg::data_t rd_q;

    // ------------------------------
    // Storage array
    // ------------------------------
    always_ff @(posedge rd_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // First read stage latching the array output
    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------
    generate
        if (opt_mode == ram_bank_pkg::OPT_MODE_TIMING) begin : g_out_reg
            logic                rd_en_d;
            ram_bank_pkg::data_t rd_out_q;

            // Enable trails the read strobe by one cycle
            always_ff @(posedge rd_clk) begin
                rd_en_d <= rd_en;
                if (rd_en_d) begin
                    rd_out_q <= rd_q;
                end
            end

            assign rd_data = rd_out_q;
        end : g_out_reg
        else begin : g_no_out_reg
            assign rd_data = rd_q;
        end : g_no_out_reg
    endgenerate

endmodule : ram_sdp_core

// File: source/ram_sdp.sv
// Bank wrapper with write/read strobe split, storage core and ack pipelines
`timescale 1ns/1ps

module ram_sdp #(
    parameter ram_bank_pkg::opt_mode_t opt_mode = ram_bank_pkg::OPT_MODE_TIMING
) (
    input  logic                    rd_clk,
    input  logic                    rst_n,
    input  ram_bank_pkg::bank_req_t req,
    output ram_bank_pkg::bank_rsp_t rsp
);

    // ------------------------------
    // Latencies
    // ------------------------------
    localparam int WR_LAT = ram_bank_pkg::WR_LATENCY;
    localparam int RD_LAT = (opt_mode == ram_bank_pkg::OPT_MODE_TIMING) ?
                            ram_bank_pkg::RD_LATENCY_TIMING :
                            ram_bank_pkg::RD_LATENCY_LATENCY;

    logic                wr_stb;
    logic                rd_stb;
    ram_bank_pkg::data_t rd_data;

    // One request per pulse split by direction
    assign wr_stb = req.en && req.we;
    assign rd_stb = req.en && !req.we;

    ram_sdp_core #(
        .opt_mode ( opt_mode )
    ) ram_sdp_core_i (
        .rd_clk  ( rd_clk    ),
        .wr_en   ( wr_stb    ),
        .wr_addr ( req.addr  ),
        .wr_data ( req.data  ),
        .rd_en   ( rd_stb    ),
        .rd_addr ( req.addr  ),
        .rd_data ( rd_data   )
    );

    // ------------------------------
    // Ack pipelines
    // ------------------------------
    // Several requests may be in flight with one bit per stage
    logic [WR_LAT-1:0] wr_pipe;
    logic [RD_LAT-1:0] rd_pipe;

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pipe <= '0;
            rd_pipe <= '0;
        end else begin
            wr_pipe[0] <= wr_stb;
            for (int i = 1; i < WR_LAT; i++) begin
                wr_pipe[i] <= wr_pipe[i-1];
            end
            rd_pipe[0] <= rd_stb;
            for (int i = 1; i < RD_LAT; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
        end
    end

    // Read data is valid only alongside a read ack
    assign rsp.ack  = wr_pipe[WR_LAT-1] | rd_pipe[RD_LAT-1];
    assign rsp.data = rd_data;

endmodule : ram_sdp

// File: source/wb_bank_decoder.sv
// Wishbone classic slave FSM issuing one bank request pulse per bus cycle
`timescale 1ns/1ps

module wb_bank_decoder (
    input  logic                    rd_clk,
    input  logic                    rst_n,
    input  ram_bank_pkg::wb_req_t   wb_req,
    input  logic                    bus_ack,
    output ram_bank_pkg::bank_req_t bank_req [ram_bank_pkg::NUM_BANKS]
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT
    } state_t;

    state_t state;
    state_t state_nxt;

    logic                     start;
    logic                     we_q;
    ram_bank_pkg::bank_sel_t  bank_sel_q;
    ram_bank_pkg::word_addr_t word_addr_q;
    ram_bank_pkg::data_t      data_q;

    assign start = wb_req.cyc && wb_req.stb;

    // ------------------------------
    // State machine
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = ISSUE;
                end
            end
            // Single-cycle request pulse
            ISSUE: state_nxt = WAIT;
            WAIT: begin
                if (bus_ack) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Capture the bus fields when a cycle is accepted
    always_ff @(posedge rd_clk) begin
        if (state == IDLE && start) begin
            we_q        <= wb_req.we;
            bank_sel_q  <= wb_req.adr[ram_bank_pkg::BUS_ADDR_WID-1 -: ram_bank_pkg::BANK_SEL_WID];
            word_addr_q <= wb_req.adr[ram_bank_pkg::WORD_ADDR_WID-1:0];
            data_q      <= wb_req.dat;
        end
    end

    // ------------------------------
    // Bank request fan-out
    // ------------------------------
    always_comb begin
        for (int i = 0; i < ram_bank_pkg::NUM_BANKS; i++) begin
            bank_req[i].en   = (state == ISSUE) &&
                               (bank_sel_q == ram_bank_pkg::bank_sel_t'(i));
            bank_req[i].we   = we_q;
            bank_req[i].addr = word_addr_q;
            bank_req[i].data = data_q;
        end
    end

endmodule : wb_bank_decoder

// File: source/bank_rsp_collector.sv
// Bank response merge with registered bus read data and ack
`timescale 1ns/1ps

module bank_rsp_collector (
    input  logic                    rd_clk,
    input  logic                    rst_n,
    input  ram_bank_pkg::bank_rsp_t bank_rsp [ram_bank_pkg::NUM_BANKS],
    output ram_bank_pkg::wb_rsp_t   wb_rsp
);

    logic                any_ack;
    ram_bank_pkg::data_t ack_data;
    logic                ack_q;
    ram_bank_pkg::data_t dat_q;

    // ------------------------------
    // Response select
    // ------------------------------
    // Only one bank acks at a time, so priority is irrelevant
    always_comb begin
        any_ack  = 1'b0;
        ack_data = '0;
        for (int i = 0; i < ram_bank_pkg::NUM_BANKS; i++) begin
            if (bank_rsp[i].ack) begin
                any_ack  = 1'b1;
                ack_data = bank_rsp[i].data;
            end
        end
    end

    // ------------------------------
    // Output registers
    // ------------------------------
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= any_ack;
        end
    end

    // Holds the last acked word between responses
    always_ff @(posedge rd_clk) begin
        if (any_ack) begin
            dat_q <= ack_data;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule : bank_rsp_collector

// File: source/banked_ram_top.sv
// Banked RAM top with bus decoder, bank array and response collector
`timescale 1ns/1ps

module banked_ram_top (
    input  logic                  rd_clk,
    input  logic                  rst_n,
    input  ram_bank_pkg::wb_req_t wb_req,
    output ram_bank_pkg::wb_rsp_t wb_rsp
);

    ram_bank_pkg::bank_req_t bank_req [ram_bank_pkg::NUM_BANKS];
    ram_bank_pkg::bank_rsp_t bank_rsp [ram_bank_pkg::NUM_BANKS];

    // ------------------------------
    // Bus cycle decode
    // ------------------------------
    wb_bank_decoder wb_bank_decoder_i (
        .rd_clk   ( rd_clk     ),
        .rst_n    ( rst_n      ),
        .wb_req   ( wb_req     ),
        .bus_ack  ( wb_rsp.ack ),
        .bank_req ( bank_req   )
    );

    // ------------------------------
    // Banks
    // ------------------------------
    generate
        for (genvar i = 0; i < ram_bank_pkg::NUM_BANKS; i++) begin : g_bank
            ram_sdp #(
                .opt_mode ( ram_bank_pkg::OPT_MODE )
            ) ram_sdp_i (
                .rd_clk ( rd_clk      ),
                .rst_n  ( rst_n       ),
                .req    ( bank_req[i] ),
                .rsp    ( bank_rsp[i] )
            );
        end : g_bank
    endgenerate

    // ------------------------------
    // Response path
    // ------------------------------
    // Adds one cycle on top of the bank latency
    bank_rsp_collector bank_rsp_collector_i (
        .rd_clk   ( rd_clk   ),
        .rst_n    ( rst_n    ),
        .bank_rsp ( bank_rsp ),
        .wb_rsp   ( wb_rsp   )
    );

endmodule : banked_ram_top

// File: dv/banked_ram_assertions.sv
// Concurrent bus and bank protocol assertions bound into banked_ram_top
`timescale 1ns/1ps

module banked_ram_assertions (
    input logic                    rd_clk,
    input logic                    rst_n,
    input ram_bank_pkg::wb_req_t   wb_req,
    input ram_bank_pkg::wb_rsp_t   wb_rsp,
    input ram_bank_pkg::bank_req_t bank_req [ram_bank_pkg::NUM_BANKS],
    input ram_bank_pkg::bank_rsp_t bank_rsp [ram_bank_pkg::NUM_BANKS]
);

    logic [ram_bank_pkg::NUM_BANKS-1:0] en_vec;
    logic [ram_bank_pkg::NUM_BANKS-1:0] ack_vec;

    always_comb begin
        for (int i = 0; i < ram_bank_pkg::NUM_BANKS; i++) begin
            en_vec[i]  = bank_req[i].en;
            ack_vec[i] = bank_rsp[i].ack;
        end
    end

    // ------------------------------
    // Bank side
    // ------------------------------
    one_bank_en: assert property (@(posedge rd_clk) disable iff (!rst_n) $onehot0(en_vec))
        else $error("More than one bank enable high in one cycle");

    one_bank_ack: assert property (@(posedge rd_clk) disable iff (!rst_n) $onehot0(ack_vec))
        else $error("More than one bank ack high in one cycle");

    // ------------------------------
    // Bus side
    // ------------------------------
    ack_single: assert property (@(posedge rd_clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("Bus ack high for two cycles in a row");

    ack_in_cycle: assert property (@(posedge rd_clk) disable iff (!rst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("Bus ack high outside an active bus cycle");

endmodule : banked_ram_assertions

bind banked_ram_top banked_ram_assertions banked_ram_assertions_i (
    .rd_clk   ( rd_clk   ),
    .rst_n    ( rst_n    ),
    .wb_req   ( wb_req   ),
    .wb_rsp   ( wb_rsp   ),
    .bank_req ( bank_req ),
    .bank_rsp ( bank_rsp )
);

// File: dv/banked_ram_tb.sv
// Testbench for banked_ram_top with clock, reset, pattern file replay, random phase and checks
`timescale 1ns/1ps

module banked_ram_tb;

    localparam int CLK_HALF    = 50;
    localparam int ACK_TIMEOUT = 20;
    localparam int MAX_PAT     = 32;
    localparam int NUM_RANDOM  = 64;
    localparam int MEM_WORDS   = 2 ** ram_bank_pkg::BUS_ADDR_WID;

    logic                  rd_clk;
    logic                  rst_n;
    ram_bank_pkg::wb_req_t wb_req;
    ram_bank_pkg::wb_rsp_t wb_rsp;

    // Pattern file triples of op, address and data
    logic [31:0]         pat_mem [3*MAX_PAT];
    ram_bank_pkg::data_t model [MEM_WORDS];
    logic                written [MEM_WORDS];
    logic [31:0]         rng_state;

    banked_ram_top banked_ram_top_i (
        .rd_clk ( rd_clk ),
        .rst_n  ( rst_n  ),
        .wb_req ( wb_req ),
        .wb_rsp ( wb_rsp )
    );

    initial begin
        rd_clk = 1'b0;
        forever #CLK_HALF rd_clk = ~rd_clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One Wishbone classic cycle with ack sampled at the falling edge
    task automatic bus_cycle(input logic we, input ram_bank_pkg::bus_addr_t adr,
                             input ram_bank_pkg::data_t wdat, input string name,
                             output ram_bank_pkg::data_t rdat);
        int   waited;
        logic got_ack;
        @(posedge rd_clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        waited  = 0;
        got_ack = 1'b0;
        while (!got_ack) begin
            @(negedge rd_clk);
            if (wb_rsp.ack) begin
                got_ack = 1'b1;
            end else begin
                waited++;
                if (waited >= ACK_TIMEOUT) begin
                    $display("No acknowledge arrived within %0d cycles for %s",
                             ACK_TIMEOUT, name);
                    $display("Errors found");
                    $fatal(1, "Bus timeout in %s", name);
                end
            end
        end
        rdat = wb_rsp.dat;
        // Master drops stb at the edge where it sees ack
        @(posedge rd_clk);
        #1;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        @(negedge rd_clk);
        check_value({name, " single ack"}, 32'd0, {31'd0, wb_rsp.ack});
    endtask

    task automatic write_word(input ram_bank_pkg::bus_addr_t adr,
                              input ram_bank_pkg::data_t dat, input string name);
        ram_bank_pkg::data_t unused;
        bus_cycle(1'b1, adr, dat, name, unused);
    endtask

    task automatic read_word(input ram_bank_pkg::bus_addr_t adr,
                             input ram_bank_pkg::data_t expected, input string name);
        ram_bank_pkg::data_t rdat;
        bus_cycle(1'b0, adr, '0, name, rdat);
        check_value(name, expected, rdat);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        ram_bank_pkg::bus_addr_t adr;
        ram_bank_pkg::data_t     dat;
        rst_n     = 1'b0;
        wb_req    = '0;
        rng_state = 32'd41;
        for (int a = 0; a < MEM_WORDS; a++) begin
            written[a] = 1'b0;
        end
        repeat (3) @(posedge rd_clk);
        #1;
        rst_n = 1'b1;

        // Idle bus after reset
        repeat (4) begin
            @(negedge rd_clk);
            check_value("idle ack", 32'd0, {31'd0, wb_rsp.ack});
        end

        // Directed phase where op 0 writes and op 1 reads with expected data
        $readmemh("dv/banked_ram_patterns.txt", pat_mem);
        for (int i = 0; i < MAX_PAT; i++) begin
            if (!$isunknown(pat_mem[3*i])) begin
                adr = pat_mem[3*i+1][ram_bank_pkg::BUS_ADDR_WID-1:0];
                dat = pat_mem[3*i+2];
                if (pat_mem[3*i] == 32'd0) begin
                    write_word(adr, dat, $sformatf("pattern %0d write", i));
                end else begin
                    read_word(adr, dat, $sformatf("pattern %0d read %h", i, adr));
                end
            end
        end

        // Random phase whose first eight writes hit the edge words of each bank
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            if (i < 8) begin
                adr = {i[2:1], {ram_bank_pkg::WORD_ADDR_WID{i[0]}}};
            end else begin
                adr = rng_state[ram_bank_pkg::BUS_ADDR_WID-1:0];
            end
            rng_state = xorshift32(rng_state);
            dat       = rng_state;
            write_word(adr, dat, $sformatf("random write %h", adr));
            model[adr]   = dat;
            written[adr] = 1'b1;
        end
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (written[a]) begin
                read_word(a[ram_bank_pkg::BUS_ADDR_WID-1:0], model[a],
                          $sformatf("random read %h", a));
            end
        end

        $display("No errors");
        $finish;
    end

endmodule : banked_ram_tb

// File: dv/banked_ram_patterns.txt
// Columns: op (0 = write, 1 = read and expect), 10-bit word address, 32-bit data
// Address bits 9:8 select the bank, bits 7:0 the word in the bank
// One word per bank, then read back
0 005 11110005
0 105 22220105
0 205 33330205
0 305 44440305
1 005 11110005
1 105 22220105
1 205 33330205
1 305 44440305
// Second write replaces the first
0 0a0 aaaa0001
0 0a0 bbbb0002
1 0a0 bbbb0002
0 3ff cccc03ff
0 3ff dddd03ff
1 3ff dddd03ff
// Bank 2 write leaves the same word in other banks alone
0 205 5555aaaa
1 005 11110005
1 105 22220105
1 205 5555aaaa
1 305 44440305
// First and last words of bank 1
0 100 0000f100
0 1ff ffff01ff
1 100 0000f100
1 1ff ffff01ff

// File: build.f
source/ram_bank_pkg.sv
source/ram_sdp_core.sv
source/ram_sdp.sv
source/wb_bank_decoder.sv
source/bank_rsp_collector.sv
source/banked_ram_top.sv
dv/banked_ram_assertions.sv
dv/banked_ram_tb.sv

// File: Bender.yml
package:
  name: banked_ram

sources:
  - source/ram_bank_pkg.sv
  - source/ram_sdp_core.sv
  - source/ram_sdp.sv
  - source/wb_bank_decoder.sv
  - source/bank_rsp_collector.sv
  - source/banked_ram_top.sv
  - target: test
    files:
      - dv/banked_ram_assertions.sv
      - dv/banked_ram_tb.sv
